//--- test/bridge_patterns.txt
# op addr data expected, all hex (W write count, M read request count, R I read byte)
# P expects the snd cmd or geo byte, K loads a key with status in addr and char in data
W 100123 5A 1
W 109FFF A5 1
W 10A000 33 0
W 17FFF0 12 0
W 200010 77 0
M 100040 00 1
M 109FFF 00 1
R 17FFF0 00 09
R 17FFF3 00 50
R 17FFF9 00 43
R 17FFFF 00 FF
R 10A000 00 FF
R 150000 00 FF
P 0000F4 5A 15A
P 0000F5 3C 03C
P 0000F6 81 081
P 0000F7 7E 07E
I 0000F1 00 00
K 00002A C1 00
I 0000F1 00 AB
I 0000F0 00 C1
I 0000F1 00 AA
K 000005 41 00
I 0000F1 00 15
I 0000F0 00 41
I 0000F1 00 14

//--- list.f
logic/z80_bus_pkg.sv
logic/bridge_map_pkg.sv
logic/z80_bus_filter.sv
logic/mem_window.sv
logic/io_port_regs.sv
logic/read_drive.sv
logic/z80_bridge.sv
test/tb_z80_bridge.sv

//--- test/tb_z80_bridge.sv
`timescale 1ns/10ps
module tb_z80_bridge;
   import z80_bus_pkg::*;
   import bridge_map_pkg::*;

   localparam int WAIT_MAX = 60;              // GPU_CLK cycles before a wait gives up
   localparam int GAP      = 8;               // Idle cycles after each bus operation
   localparam int RAM_LAT  = 3;               // GPU RAM model answer delay

   logic              GPU_CLK = 1'b0;
   logic              reset, z80_clk, m1_n, mreq_n, iorq_n, rd_n, wr_n;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata, gpu_rdata, z80_rdata;
   logic              gpu_rd_rdy, ps2_rdy, rdata_ena, data_dir, oe_n;
   logic [7:0]        ps2_dat, ps2_status;
   gpu_req_t          gpu_req;
   snd_cmd_t          snd;
   geo_wr_t           geo;

   integer            seed = 27201;           // RAM model data
   int                ram_wait, wr_cnt, rd_cnt, snd_cnt, lo_cnt, hi_cnt;
   int                n_tests, n_fail;
   logic [19:0]       last_adr;               // Last GPU write address
   logic [8:0]        last_wr, last_snd, last_lo, last_hi;
   logic [7:0]        ram_exp;                // Byte the RAM model last returned
   logic              test_ok;
   string             test_name;

   always #10 GPU_CLK = ~GPU_CLK;             // 20 ns period
   always #60 z80_clk = ~z80_clk;             // Host clock toggling on GPU_CLK falling edges

   z80_bridge i_z80_bridge (
      .GPU_CLK(GPU_CLK), .reset(reset), .z80_clk(z80_clk), .m1_n(m1_n), .mreq_n(mreq_n),
      .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .addr(addr), .wdata(wdata),
      .gpu_rdata(gpu_rdata), .gpu_rd_rdy(gpu_rd_rdy), .ps2_rdy(ps2_rdy), .ps2_dat(ps2_dat),
      .ps2_status(ps2_status), .gpu_req(gpu_req), .snd(snd), .geo(geo),
      .z80_rdata(z80_rdata), .rdata_ena(rdata_ena), .data_dir(data_dir), .oe_n(oe_n)
   );

   // **********************************************************************
   // One GPU_CLK step with the RAM model and the strobe monitor
   // **********************************************************************
   task automatic tick();
      int r;
      @(negedge GPU_CLK);                     // Outputs settled and inputs may change
      gpu_rd_rdy = 1'b0;
      if (ram_wait > 0) begin
         ram_wait--;
         if (ram_wait == 0) begin
            r          = $random(seed);
            gpu_rdata  = r[7:0];
            ram_exp    = r[7:0];              // Expected read answer
            gpu_rd_rdy = 1'b1;                // Single cycle answer
         end
      end
      if (gpu_req.rd_req) begin
         rd_cnt++;
         ram_wait = RAM_LAT;
      end
      if (gpu_req.wr_ena) begin
         wr_cnt++;
         last_adr = gpu_req.addr;
         last_wr  = {1'b0, gpu_req.wdata};
      end
      if (snd.tx) begin
         snd_cnt++;
         last_snd = snd.cmd;
      end
      if (geo.lo_stb) begin
         lo_cnt++;
         last_lo = {1'b0, geo.lo};
      end
      if (geo.hi_stb) begin
         hi_cnt++;
         last_hi = {1'b0, geo.hi};
      end
   endtask

   task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, exp, act);
      test_ok = 1'b0;
   endtask

   task automatic complain(input string msg);
      $display("ERROR %s %s", test_name, msg);
      test_ok = 1'b0;
   endtask

   function automatic int strobes();
      return wr_cnt + snd_cnt + lo_cnt + hi_cnt; // All write side pulses
   endfunction

   task automatic drive_cycle(input logic is_io, input logic is_wr, input logic [21:0] a,
                              input logic [7:0] d);
      addr   = a;
      wdata  = d;
      mreq_n = is_io;
      iorq_n = ~is_io;
      rd_n   = is_wr;
      wr_n   = ~is_wr;
   endtask

   task automatic release_bus();
      m1_n   = 1'b1;
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
   endtask

   // **********************************************************************
   // Z80 bus cycles
   // **********************************************************************
   task automatic bus_write(input logic is_io, input logic [21:0] a, input logic [7:0] d);
      int base, n;
      base = strobes();
      n    = 0;
      tick();
      drive_cycle(is_io, 1'b1, a, d);
      while (strobes() == base && n < WAIT_MAX) begin // Out of range writes run to the limit
         tick();
         n++;
      end
      release_bus();
      repeat (GAP) tick();                    // Still counting stray strobes
   endtask

   task automatic bus_read(input logic is_io, input logic [21:0] a, output logic [7:0] got);
      int n;
      n = 0;
      tick();
      drive_cycle(is_io, 1'b0, a, 8'h00);
      while (!rdata_ena && n < WAIT_MAX) begin
         tick();
         n++;
      end
      if (!rdata_ena) complain("rdata_ena never rose during the read");
      got = z80_rdata;
      if (data_dir !== DATA_OUT) mismatch("data_dir", DATA_OUT, data_dir);
      repeat (2) begin                        // Data must hold while RD stays low
         tick();
         if (rdata_ena && z80_rdata !== got) mismatch("held data", got, z80_rdata);
         if (rdata_ena && oe_n !== 1'b0) mismatch("oe_n while driving", 1'b0, oe_n);
      end
      release_bus();
      n = 0;
      while ((rdata_ena || data_dir !== DATA_IN) && n < WAIT_MAX) begin
         tick();
         n++;
      end
      if (rdata_ena || data_dir !== DATA_IN) complain("bus not turned around after RD release");
      repeat (GAP) tick();
      if (oe_n !== 1'b0) mismatch("oe_n idle", 1'b0, oe_n);
   endtask

   task automatic load_key(input logic [7:0] dat, input logic [7:0] stat);
      tick();
      ps2_dat    = dat;
      ps2_status = stat;
      ps2_rdy    = 1'b1;
      repeat (10) tick();                     // Ready pulse length
      ps2_rdy = 1'b0;
      repeat (GAP) tick();
   endtask

   task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] d,
                         input logic [31:0] e, input int lineno);
      int         b_wr, b_rd, b_snd, b_lo, b_hi;
      logic [7:0] got;
      b_wr      = wr_cnt;
      b_rd      = rd_cnt;
      b_snd     = snd_cnt;
      b_lo      = lo_cnt;
      b_hi      = hi_cnt;
      test_ok   = 1'b1;
      test_name = $sformatf("%c %06h (line %0d)", op, a[21:0], lineno);
      case (op)
         "W": begin                           // Expected column is the strobe count
            bus_write(1'b0, a[21:0], d[7:0]);
            if (wr_cnt - b_wr != e) mismatch("write strobes", e, wr_cnt - b_wr);
            if (e == 1 && last_adr !== a[19:0]) mismatch("gpu address", a[19:0], last_adr);
            if (e == 1 && last_wr !== {1'b0, d[7:0]}) mismatch("gpu data", d[7:0], last_wr);
         end
         "M": begin                           // RAM read with data from the model
            bus_read(1'b0, a[21:0], got);
            if (rd_cnt - b_rd != e) mismatch("read requests", e, rd_cnt - b_rd);
            if (got !== ram_exp) mismatch("read data", ram_exp, got);
         end
         "R": begin
            bus_read(1'b0, a[21:0], got);
            if (rd_cnt != b_rd) mismatch("read requests", 0, rd_cnt - b_rd);
            if (got !== e[7:0]) mismatch("read data", e[7:0], got);
         end
         "I": begin
            bus_read(1'b1, a[21:0], got);
            if (got !== e[7:0]) mismatch("port data", e[7:0], got);
         end
         "P": begin
            bus_write(1'b1, a[21:0], d[7:0]);
            case (a[7:0])
               8'd244, 8'd245: begin
                  if (snd_cnt - b_snd != 1) mismatch("snd tx pulses", 1, snd_cnt - b_snd);
                  if (last_snd !== e[8:0]) mismatch("snd cmd", e[8:0], last_snd);
               end
               8'd246: begin
                  if (lo_cnt - b_lo != 1) mismatch("geo low strobes", 1, lo_cnt - b_lo);
                  if (last_lo !== e[8:0]) mismatch("geo low byte", e[8:0], last_lo);
               end
               8'd247: begin
                  if (hi_cnt - b_hi != 1) mismatch("geo high strobes", 1, hi_cnt - b_hi);
                  if (last_hi !== e[8:0]) mismatch("geo high byte", e[8:0], last_hi);
               end
               default: complain("pattern names no output port");
            endcase
         end
         "K": load_key(d[7:0], a[7:0]);       // Setup step with status in the address column
         default: complain("unknown operation letter in the pattern file");
      endcase
      if (op != "K") begin
         $display("%s %s", test_name, test_ok ? "ok" : "failed");
         n_tests++;
         if (!test_ok) n_fail++;
      end
   endtask

   // **********************************************************************
   // Pattern loop
   // **********************************************************************
   initial begin
      integer      fd, code, lineno;
      string       line;
      logic [7:0]  op;
      logic [31:0] a, d, e;
      reset      = 1'b1;
      z80_clk    = 1'b0;
      gpu_rdata  = 8'h00;
      gpu_rd_rdy = 1'b0;
      ps2_rdy    = 1'b0;
      ps2_dat    = 8'h00;
      ps2_status = 8'h00;
      addr       = '0;
      wdata      = 8'h00;
      release_bus();
      repeat (5) tick();
      reset = 1'b0;
      repeat (GAP) tick();
      fd = $fopen("test/bridge_patterns.txt", "r");
      if (fd == 0) begin
         $display("ERROR cannot open test/bridge_patterns.txt");
         n_fail++;
      end else begin
         lineno = 0;
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            lineno++;
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
               code = $sscanf(line, "%c %h %h %h", op, a, d, e);
               if (code != 4) begin
                  $display("ERROR pattern line %0d cannot be parsed", lineno);
                  n_fail++;
               end else begin
                  run_op(op, a, d, e, lineno);
               end
            end
         end
         $fclose(fd);
      end
      $display("tests run %0d, failed %0d", n_tests, n_fail);
      if (n_fail == 0 && n_tests > 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- logic/z80_bridge.sv
`timescale 1ns/10ps
module z80_bridge (
   input  logic                             GPU_CLK,
   input  logic                             reset,
   input  logic                             z80_clk,
   input  logic                             m1_n,
   input  logic                             mreq_n,
   input  logic                             iorq_n,
   input  logic                             rd_n,
   input  logic                             wr_n,
   input  logic [z80_bus_pkg::ADDR_W-1:0]   addr,
   input  logic [z80_bus_pkg::DATA_W-1:0]   wdata,
   input  logic [z80_bus_pkg::DATA_W-1:0]   gpu_rdata,
   input  logic                             gpu_rd_rdy,
   input  logic                             ps2_rdy,
   input  logic [7:0]                       ps2_dat,
   input  logic [7:0]                       ps2_status,
   output bridge_map_pkg::gpu_req_t         gpu_req,
   output bridge_map_pkg::snd_cmd_t         snd,
   output bridge_map_pkg::geo_wr_t          geo,
   output logic [z80_bus_pkg::DATA_W-1:0]   z80_rdata,
   output logic                             rdata_ena,
   output logic                             data_dir,
   output logic                             oe_n
);
   import z80_bus_pkg::*;
   import bridge_map_pkg::*;

   z80_bus_t   bus;                           // Filtered bus sample
   read_resp_t mem_resp;                      // Memory window answer
   read_resp_t port_resp;                     // Keyboard port answer

   z80_bus_filter i_z80_bus_filter (
      .GPU_CLK(GPU_CLK), .reset(reset), .z80_clk(z80_clk), .m1_n(m1_n),
      .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .addr(addr), .wdata(wdata), .bus(bus)
   );

   mem_window i_mem_window (
      .GPU_CLK(GPU_CLK), .reset(reset), .bus(bus), .gpu_rdata(gpu_rdata),
      .gpu_rd_rdy(gpu_rd_rdy), .gpu_req(gpu_req), .mem_resp(mem_resp)
   );

   io_port_regs i_io_port_regs (
      .GPU_CLK(GPU_CLK), .reset(reset), .bus(bus), .ps2_rdy(ps2_rdy),
      .ps2_dat(ps2_dat), .ps2_status(ps2_status), .snd(snd), .geo(geo),
      .port_resp(port_resp)
   );

   read_drive i_read_drive (
      .GPU_CLK(GPU_CLK), .reset(reset), .bus(bus), .mem_resp(mem_resp),
      .port_resp(port_resp), .z80_rdata(z80_rdata), .rdata_ena(rdata_ena),
      .data_dir(data_dir), .oe_n(oe_n)
   );

endmodule

//--- logic/read_drive.sv
`timescale 1ns/10ps
module read_drive (
   input  logic                             GPU_CLK,
   input  logic                             reset,
   input  z80_bus_pkg::z80_bus_t            bus,
   input  bridge_map_pkg::read_resp_t       mem_resp,
   input  bridge_map_pkg::read_resp_t       port_resp,
   output logic [z80_bus_pkg::DATA_W-1:0]   z80_rdata,
   output logic                             rdata_ena,   // Drive z80_rdata onto the bus
   output logic                             data_dir,    // 245 direction
   output logic                             oe_n         // 245 enable
);
   import z80_bus_pkg::*;
   import bridge_map_pkg::*;

   logic              rd_act;                 // Read cycle in progress
   logic              ena_q, dir_q, dir_d;
   logic [DATA_W-1:0] data_q;
   logic [DATA_W+2:0] stg1, stg2;             // {oe_n, dir, ena, data}

   assign rd_act = (bus.cycle == cyc_mem_rd) || (bus.cycle == cyc_io_rd);

   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         ena_q <= 1'b0;
         dir_q <= DATA_IN;
         dir_d <= DATA_IN;
         stg1  <= {1'b0, DATA_IN, 1'b0, {DATA_W{1'b0}}};
         stg2  <= {1'b0, DATA_IN, 1'b0, {DATA_W{1'b0}}};
      end else begin
         if (!rd_act) begin
            ena_q <= 1'b0;                    // RD released so turn the bus around
            dir_q <= DATA_IN;
         end else if (!ena_q && (mem_resp.valid || port_resp.valid)) begin
            ena_q <= 1'b1;
            dir_q <= DATA_OUT;
         end
         dir_d <= dir_q;
         stg1  <= {dir_q ^ dir_d, dir_q, ena_q, data_q};  // Converter off while turning
         stg2  <= stg1;                                   // Second stage toward slow bus
      end
      if (rd_act && !ena_q) begin             // Capture the first answer only
         data_q <= mem_resp.valid ? mem_resp.data : port_resp.data;
      end
   end

   assign {oe_n, data_dir, rdata_ena, z80_rdata} = stg2;

endmodule

//--- logic/io_port_regs.sv
`timescale 1ns/10ps
module io_port_regs (
   input  logic                             GPU_CLK,
   input  logic                             reset,
   input  z80_bus_pkg::z80_bus_t            bus,
   input  logic                             ps2_rdy,      // Keyboard character ready
   input  logic [7:0]                       ps2_dat,
   input  logic [7:0]                       ps2_status,
   output bridge_map_pkg::snd_cmd_t         snd,
   output bridge_map_pkg::geo_wr_t          geo,
   output bridge_map_pkg::read_resp_t       port_resp
);
   import z80_bus_pkg::*;
   import bridge_map_pkg::*;

   logic [7:0] port;                          // Low address byte selects the port
   logic       wr_go;                         // First cycle of a port write
   logic       rd_char;                       // First cycle of a data port read
   logic       kbd_sel;
   logic [7:0] rdy_sr;                        // ps2_rdy history
   logic [7:0] kbd_char;
   logic [7:0] kbd_stat;                      // Bit 0 is the ready flag

   assign port    = bus.addr[7:0];
   assign wr_go   = bus.start && (bus.cycle == cyc_io_wr);
   assign rd_char = bus.start && (bus.cycle == cyc_io_rd) && (port == port_kbd_data);
   assign kbd_sel = (port == port_kbd_data) || (port == port_kbd_stat);

   // ********************************************************************
   // Write strobes
   // ********************************************************************
   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         snd.tx     <= 1'b0;
         geo.lo_stb <= 1'b0;
         geo.hi_stb <= 1'b0;
      end else begin
         snd.tx     <= wr_go && ((port == port_snd_ton) || (port == port_snd_dur));
         geo.lo_stb <= wr_go && (port == port_geo_lo);
         geo.hi_stb <= wr_go && (port == port_geo_hi);
      end
      if (wr_go) snd.cmd <= {port == port_snd_ton, bus.wdata};   // Bit 8 low means stop
      if (wr_go && (port == port_geo_lo)) geo.lo <= bus.wdata;
      if (wr_go && (port == port_geo_hi)) geo.hi <= bus.wdata;
   end

   // ********************************************************************
   // Keyboard latch
   // ********************************************************************
   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         rdy_sr   <= '0;
         kbd_char <= '0;
         kbd_stat <= '0;
      end else begin
         rdy_sr <= {rdy_sr[6:0], ps2_rdy};
         if (rd_char) begin
            kbd_char    <= '0;                // Character consumed
            kbd_stat[0] <= 1'b0;
         end
         if (rdy_sr == 8'b0000_1111) begin    // Ready settled for four cycles
            kbd_char <= ps2_dat;
            kbd_stat <= {ps2_status[5:0], ps2_dat[7], 1'b1};
         end
      end
   end

   always_comb begin
      port_resp.valid = (bus.cycle == cyc_io_rd) && kbd_sel;
      port_resp.data  = (port == port_kbd_data) ? kbd_char : kbd_stat;
   end

   a_snd_pulse: assert property (@(posedge GPU_CLK) disable iff (reset)
      snd.tx |=> !snd.tx);

endmodule

//--- logic/mem_window.sv
`timescale 1ns/10ps
module mem_window (
   input  logic                             GPU_CLK,
   input  logic                             reset,
   input  z80_bus_pkg::z80_bus_t            bus,
   input  logic [z80_bus_pkg::DATA_W-1:0]   gpu_rdata,
   input  logic                             gpu_rd_rdy,   // One cycle when gpu_rdata valid
   output bridge_map_pkg::gpu_req_t         gpu_req,
   output bridge_map_pkg::read_resp_t       mem_resp
);
   import z80_bus_pkg::*;
   import bridge_map_pkg::*;

   logic              in_bank, in_range, in_id;
   logic              is_rd;                      // Memory read in the window
   logic              rd_pend, rd_got;            // RAM answer outstanding or held
   logic              ram_ack;
   logic [DATA_W-1:0] ram_data;

   assign in_bank  = (bus.addr[21:19] == MEM_RANGE);
   assign in_range = in_bank && (bus.addr[18:0] < MEM_SIZE_BYTES);
   assign in_id    = in_bank && (bus.addr[18:4] == BANK_ID_ADDR);
   assign is_rd    = (bus.cycle == cyc_mem_rd) && in_bank;
   assign ram_ack  = (gpu_req.rd_req || rd_pend) && gpu_rd_rdy;

   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         gpu_req.wr_ena <= 1'b0;
         gpu_req.rd_req <= 1'b0;
         rd_pend        <= 1'b0;
         rd_got         <= 1'b0;
      end else begin
         gpu_req.wr_ena <= bus.start && (bus.cycle == cyc_mem_wr) && in_range;
         gpu_req.rd_req <= bus.start && (bus.cycle == cyc_mem_rd) && in_range;
         if (!is_rd) begin
            rd_pend <= 1'b0;                      // Cycle over so drop the request
            rd_got  <= 1'b0;
         end else if (ram_ack) begin
            rd_pend <= 1'b0;
            rd_got  <= 1'b1;
         end else if (gpu_req.rd_req) begin
            rd_pend <= 1'b1;
         end
      end
      if (bus.start && in_range) begin
         gpu_req.addr  <= bus.addr[GPU_ADDR_W-1:0];
         gpu_req.wdata <= bus.wdata;
      end
      if (ram_ack) ram_data <= gpu_rdata;         // Hold for the rest of the cycle
   end

   always_comb begin
      mem_resp.valid = is_rd && (!in_range || ram_ack || rd_got);
      if (in_range)   mem_resp.data = ram_ack ? gpu_rdata : ram_data;
      else if (in_id) mem_resp.data = BANK_ID[bus.addr[3:0]];  // Bank signature
      else            mem_resp.data = 8'hFF;                   // Unpopulated window
   end

   a_req_pulse: assert property (@(posedge GPU_CLK) disable iff (reset)
      (gpu_req.wr_ena || gpu_req.rd_req) |=> !(gpu_req.wr_ena || gpu_req.rd_req));

endmodule

//--- logic/z80_bus_filter.sv
`timescale 1ns/10ps
module z80_bus_filter (
   input  logic                             GPU_CLK,
   input  logic                             reset,
   input  logic                             z80_clk,  // Host bus clock
   input  logic                             m1_n,
   input  logic                             mreq_n,
   input  logic                             iorq_n,
   input  logic                             rd_n,
   input  logic                             wr_n,
   input  logic [z80_bus_pkg::ADDR_W-1:0]   addr,
   input  logic [z80_bus_pkg::DATA_W-1:0]   wdata,
   output z80_bus_pkg::z80_bus_t            bus
);
   import z80_bus_pkg::*;

   logic [2:0]                    clk_sr;                // Pin register then two sync flops
   logic                          m1_n_r, mreq_n_r, iorq_n_r, rd_n_r, wr_n_r;
   logic [ADDR_W-1:0]             addr_r;
   logic [DATA_W-1:0]             wdata_r;
   logic                          zclk;                  // Either Z80_CLK edge
   logic [cyc_io_wr:cyc_opcode]   op;                    // Raw decoded controls
   logic [cyc_io_wr:cyc_opcode]   rel;                   // Strobe released
   logic [cyc_io_wr:cyc_opcode]   hit, hit_d;            // Accepted cycle flags
   logic [2:0]                    fc [cyc_opcode:cyc_io_wr];
   bus_cycle_e                    cyc_nxt;

   function automatic logic [2:0] filter_len(input int c);
      return (c >= cyc_io_rd) ? FILTER_PORT : FILTER_MEM; // Ports filter longer
   endfunction

   assign zclk = clk_sr[2] ^ clk_sr[1];

   always_comb begin
      op[cyc_opcode] = ~m1_n_r &  iorq_n_r & ~mreq_n_r & ~rd_n_r &  wr_n_r;
      op[cyc_mem_rd] =  m1_n_r &  iorq_n_r & ~mreq_n_r & ~rd_n_r &  wr_n_r;
      op[cyc_mem_wr] =  m1_n_r &  iorq_n_r & ~mreq_n_r &  rd_n_r & ~wr_n_r;
      op[cyc_io_rd]  =  m1_n_r & ~iorq_n_r &  mreq_n_r & ~rd_n_r &  wr_n_r;
      op[cyc_io_wr]  =  m1_n_r & ~iorq_n_r &  mreq_n_r &  rd_n_r & ~wr_n_r;
      rel = {wr_n_r, rd_n_r, wr_n_r, rd_n_r, rd_n_r};    // io_wr down to opcode
      cyc_nxt = cyc_idle;
      for (int c = cyc_opcode; c <= cyc_io_wr; c++) begin
         if (hit[c]) cyc_nxt = bus_cycle_e'(c);           // One flag at a time
      end
   end

   // ********************************************************************
   // Pin sampling and stability filters
   // ********************************************************************
   always_ff @(posedge GPU_CLK) begin
      clk_sr   <= {clk_sr[1:0], z80_clk};
      m1_n_r   <= m1_n;
      mreq_n_r <= mreq_n;
      iorq_n_r <= iorq_n;
      rd_n_r   <= rd_n;
      wr_n_r   <= wr_n;
      addr_r   <= addr;
      wdata_r  <= wdata;
   end

   always_ff @(posedge GPU_CLK) begin
      if (reset) begin
         for (int c = cyc_opcode; c <= cyc_io_wr; c++) begin
            fc[c] <= '0;
         end
         hit       <= '0;
         hit_d     <= '0;
         bus.cycle <= cyc_idle;
         bus.start <= 1'b0;
      end else begin
         for (int c = cyc_opcode; c <= cyc_io_wr; c++) begin
            if (rel[c]) begin
               fc[c]  <= '0;                              // Strobe gone so restart
               hit[c] <= 1'b0;
            end else if (zclk && op[c]) begin
               if (fc[c] != filter_len(c)) fc[c] <= fc[c] + 3'd1;
               else                        hit[c] <= 1'b1; // Stable long enough
            end
         end
         hit_d     <= hit;
         bus.cycle <= cyc_nxt;
         bus.start <= |(hit & ~hit_d);                    // Rising edge of any flag
      end
      bus.addr  <= addr_r;                                // Payload follows the flags
      bus.wdata <= wdata_r;
   end

   a_start_pulse: assert property (@(posedge GPU_CLK) disable iff (reset)
      bus.start |=> !bus.start);

endmodule

//--- logic/bridge_map_pkg.sv
package bridge_map_pkg;

   // ********************************************************************
   // Memory map
   // ********************************************************************
   localparam logic [2:0]  MEM_RANGE      = 3'b010;   // 512 KB window in socket 3
   localparam int          MEM_SIZE_BYTES = 40960;    // Above this the window returns 0xFF
   localparam logic [14:0] BANK_ID_ADDR   = 15'h7FFF; // Top 16 bytes of the window

   localparam logic [7:0] BANK_ID [16] = '{
      8'd9, 8'd3, 8'd71, 8'd80, 8'd85, 8'd32, 8'd69, 8'd80,
      8'd52, 8'd67, 8'd69, 8'd49, 8'd48, 8'd0, 8'd255, 8'd255
   };

   // ********************************************************************
   // IO ports and buffer direction
   // ********************************************************************
   typedef enum logic [7:0] {
      port_kbd_data = 8'd240,                 // Keyboard character
      port_kbd_stat = 8'd241,                 // Keyboard status
      port_snd_ton  = 8'd244,                 // Sound tone
      port_snd_dur  = 8'd245,                 // Sound stop
      port_geo_lo   = 8'd246,                 // Geometry low byte
      port_geo_hi   = 8'd247                  // Geometry high byte
   } io_port_e;

   localparam logic DATA_IN  = 1'b0;          // 245 points toward the FPGA
   localparam logic DATA_OUT = 1'b1;          // 245 points toward the Z80

   typedef struct packed {
      logic                                 wr_ena;  // GPU RAM write strobe
      logic                                 rd_req;  // GPU RAM read request
      logic [z80_bus_pkg::GPU_ADDR_W-1:0]   addr;
      logic [z80_bus_pkg::DATA_W-1:0]       wdata;
   } gpu_req_t;

   typedef struct packed {
      logic                                 valid;   // Answer known for this read
      logic [z80_bus_pkg::DATA_W-1:0]       data;
   } read_resp_t;

   typedef struct packed {
      logic       tx;                         // One cycle per command
      logic [8:0] cmd;                        // Bit 8 high for tone
   } snd_cmd_t;

   typedef struct packed {
      logic       lo_stb;
      logic [7:0] lo;
      logic       hi_stb;
      logic [7:0] hi;
   } geo_wr_t;

endpackage

//--- logic/z80_bus_pkg.sv
package z80_bus_pkg;

   // ********************************************************************
   // Bus widths and filter lengths
   // ********************************************************************
   localparam int ADDR_W     = 22;             // Z80 extended address bus
   localparam int DATA_W     = 8;              // Z80 data bus
   localparam int GPU_ADDR_W = 20;             // GPU RAM address

   localparam logic [2:0] FILTER_MEM  = 3'd0;  // Stable edges for memory and opcode cycles
   localparam logic [2:0] FILTER_PORT = 3'd2;  // Stable edges for IO cycles

   // ********************************************************************
   // Bus cycle types and the registered bus sample
   // ********************************************************************
   typedef enum logic [2:0] {
      cyc_idle   = 3'd0,                       // No accepted cycle
      cyc_opcode = 3'd1,                       // M1 opcode fetch
      cyc_mem_rd = 3'd2,                       // Memory read
      cyc_mem_wr = 3'd3,                       // Memory write
      cyc_io_rd  = 3'd4,                       // Port read
      cyc_io_wr  = 3'd5                        // Port write
   } bus_cycle_e;

   typedef struct packed {
      bus_cycle_e          cycle;              // Filtered cycle type
      logic                start;              // One GPU_CLK at cycle start
      logic [ADDR_W-1:0]   addr;               // Registered address
      logic [DATA_W-1:0]   wdata;              // Registered write data
   } z80_bus_t;

endpackage
